//--- game_defines.svh
`ifndef GAME_DEFINES_SVH
`define GAME_DEFINES_SVH

// datapath widths
`define TIME_W          18
`define COORD_W         12
`define PIX_X_W         11
`define PIX_Y_W         10
`define SCORE_W         12
`define HEALTH_W        4
`define COMBO_W         3

// chart timing, in game ticks
`define TICK_CYCLES     4
`define NUM_NOTES       4
`define APPROACH_TICKS  10
`define HIT_WINDOW      3

// hit geometry and drawing
`define HIT_RADIUS      24
`define NOTE_HALF       16
`define MAX_HEALTH      8
`define COMBO_MAX       7
`define HUD_H           16
`define HEALTH_SEG      20

`endif

//--- game_pkg.sv
`default_nettype none

package game_pkg;

    // overall play state of the game
    typedef enum logic [1:0] {
        PLAYING = 2'd0,
        DONE    = 2'd1
    } play_state_e;

endpackage

`default_nettype wire

//--- game_ifs.sv
`timescale 1ns/1ps
`default_nettype none
`include "game_defines.svh"

//////////////////////////////////////////////////////////////////////
// current note, as seen by judge and renderer
//////////////////////////////////////////////////////////////////////
interface note_if;
    logic [`COORD_W-1:0] note_x;
    logic [`COORD_W-1:0] note_y;
    logic                note_color;
    logic                note_visible;
    logic                hit_open;
    logic                expired;
    logic                all_done;
    // one-cycle pulse, moves the track to the next note
    logic                resolve;

    modport track (output note_x, note_y, note_color, note_visible,
                   output hit_open, expired, all_done,
                   input  resolve);
    modport judge (input  note_x, note_y, note_color, hit_open, expired,
                   output resolve);
    modport view  (input  note_x, note_y, note_color, note_visible);
endinterface

//////////////////////////////////////////////////////////////////////
// tracked hand positions
//////////////////////////////////////////////////////////////////////
interface hand_if;
    logic [`COORD_W-1:0] left_x;
    logic [`COORD_W-1:0] left_y;
    logic [`COORD_W-1:0] right_x;
    logic [`COORD_W-1:0] right_y;

    modport src   (output left_x, left_y, right_x, right_y);
    modport judge (input  left_x, left_y, right_x, right_y);
endinterface

`default_nettype wire

//--- note_track.sv
`timescale 1ns/1ps
`default_nettype none
`include "game_defines.svh"

module note_track (
    input wire                clk_in,
    input wire                rst_in,
    input wire [`TIME_W-1:0]  curr_time,
    note_if.track             note
);
    localparam int PTR_W = $clog2(`NUM_NOTES + 1);
    localparam int IDX_W = $clog2(`NUM_NOTES);

    //////////////////////////////////////////////////////////////////////
    // note chart
    //////////////////////////////////////////////////////////////////////
    localparam logic [`TIME_W-1:0] HIT_T [`NUM_NOTES] =
        '{`TIME_W'(20), `TIME_W'(40), `TIME_W'(60), `TIME_W'(80)};
    // 0 is red (left hand), 1 is blue (right hand)
    localparam logic NOTE_C [`NUM_NOTES] = '{1'b0, 1'b1, 1'b0, 1'b1};
    localparam logic [`COORD_W-1:0] NOTE_X [`NUM_NOTES] =
        '{`COORD_W'(200), `COORD_W'(400), `COORD_W'(300), `COORD_W'(500)};
    localparam logic [`COORD_W-1:0] NOTE_Y [`NUM_NOTES] =
        '{`COORD_W'(150), `COORD_W'(150), `COORD_W'(300), `COORD_W'(300)};

    // windows compared one bit wider so the sums cannot wrap
    localparam logic [`TIME_W:0] APPROACH = (`TIME_W + 1)'(`APPROACH_TICKS);
    localparam logic [`TIME_W:0] WINDOW   = (`TIME_W + 1)'(`HIT_WINDOW);

    logic [PTR_W-1:0] ptr;
    logic [IDX_W-1:0] idx;
    logic             done;
    logic [`TIME_W:0] t_ext;
    logic [`TIME_W:0] hit_ext;

    assign done    = (ptr == PTR_W'(`NUM_NOTES));
    assign idx     = ptr[IDX_W-1:0];
    assign t_ext   = {1'b0, curr_time};
    assign hit_ext = {1'b0, HIT_T[idx]};

    // advance on the resolve edge, stop at the end of the chart
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            ptr <= '0;
        end else if (note.resolve && !done) begin
            ptr <= ptr + PTR_W'(1);
        end
    end

    assign note.note_x     = NOTE_X[idx];
    assign note.note_y     = NOTE_Y[idx];
    assign note.note_color = NOTE_C[idx];
    assign note.all_done   = done;

    // window flags, all forced low once the chart is finished
    assign note.note_visible = !done && (t_ext + APPROACH >= hit_ext);
    assign note.hit_open     = !done && (t_ext + WINDOW >= hit_ext)
                                     && (t_ext <= hit_ext + WINDOW);
    assign note.expired      = !done && (t_ext > hit_ext + WINDOW);

endmodule

`default_nettype wire

//--- slice_judge.sv
`timescale 1ns/1ps
`default_nettype none
`include "game_defines.svh"

module slice_judge (
    input wire    clk_in,
    input wire    rst_in,
    note_if.judge note,
    hand_if.judge hands,
    output logic  slice,
    output logic  miss
);
    logic [`COORD_W-1:0] hx;
    logic [`COORD_W-1:0] hy;
    logic [`COORD_W-1:0] dx;
    logic [`COORD_W-1:0] dy;
    logic                in_box;

    // hand matching the note colour
    assign hx = note.note_color ? hands.right_x : hands.left_x;
    assign hy = note.note_color ? hands.right_y : hands.left_y;

    // distance on each axis
    assign dx = (hx >= note.note_x) ? hx - note.note_x : note.note_x - hx;
    assign dy = (hy >= note.note_y) ? hy - note.note_y : note.note_y - hy;

    // square hit box
    assign in_box = (dx <= `COORD_W'(`HIT_RADIUS)) && (dy <= `COORD_W'(`HIT_RADIUS));

    //////////////////////////////////////////////////////////////////////
    // pulse registers
    //////////////////////////////////////////////////////////////////////
    // the track still shows the old note while resolve is high,
    // so nothing is judged in that cycle
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            slice <= 1'b0;
            miss  <= 1'b0;
        end else begin
            slice <= note.hit_open && in_box && !note.resolve;
            miss  <= note.expired && !note.resolve;
        end
    end

    assign note.resolve = slice | miss;

endmodule

`default_nettype wire

//--- game_state.sv
`timescale 1ns/1ps
`default_nettype none
`include "game_defines.svh"

module game_state (
    input wire                    clk_in,
    input wire                    rst_in,
    input wire                    slice,
    input wire                    miss,
    input wire                    all_done,
    output logic [`TIME_W-1:0]    curr_time,
    output logic [`SCORE_W-1:0]   score,
    output logic [`COMBO_W-1:0]   combo,
    output logic [`HEALTH_W-1:0]  health,
    output game_pkg::play_state_e state
);
    import game_pkg::*;

    localparam int PRE_W = $clog2(`TICK_CYCLES);

    logic [PRE_W-1:0] presc;
    logic             tick;

    assign tick = (presc == PRE_W'(`TICK_CYCLES - 1));

    //////////////////////////////////////////////////////////////////////
    // game clock
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            presc     <= '0;
            curr_time <= '0;
        end else begin
            presc <= tick ? '0 : presc + PRE_W'(1);
            // frozen once the game is over
            if (tick && state == PLAYING) begin
                curr_time <= curr_time + `TIME_W'(1);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // score, combo, health
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            score  <= '0;
            combo  <= '0;
            health <= `HEALTH_W'(`MAX_HEALTH);
        end else if (slice) begin
            // old combo is the bonus
            score <= score + `SCORE_W'(combo) + `SCORE_W'(1);
            if (combo != `COMBO_W'(`COMBO_MAX)) begin
                combo <= combo + `COMBO_W'(1);
            end
        end else if (miss) begin
            combo <= '0;
            if (health != '0) begin
                health <= health - `HEALTH_W'(1);
            end
        end
    end

    // done one cycle after the chart runs out
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= PLAYING;
        end else if (all_done) begin
            state <= DONE;
        end
    end

endmodule

`default_nettype wire

//--- pixel_renderer.sv
`timescale 1ns/1ps
`default_nettype none
`include "game_defines.svh"

module pixel_renderer (
    input wire                    clk_in,
    input wire                    rst_in,
    input wire [`PIX_X_W-1:0]     x_in,
    input wire [`PIX_Y_W-1:0]     y_in,
    input wire [`HEALTH_W-1:0]    health,
    input wire game_pkg::play_state_e state,
    note_if.view                  note,
    output logic [3:0]            r_out,
    output logic [3:0]            g_out,
    output logic [3:0]            b_out
);
    import game_pkg::*;

    logic [`COORD_W-1:0] px;
    logic [`COORD_W-1:0] py;
    logic [`COORD_W-1:0] dx;
    logic [`COORD_W-1:0] dy;
    logic [`PIX_X_W-1:0] bar_w;
    logic                on_bar;
    logic                in_note;

    // health bar along the top band
    assign bar_w  = `PIX_X_W'(health) * `PIX_X_W'(`HEALTH_SEG);
    assign on_bar = (y_in < `PIX_Y_W'(`HUD_H)) && (x_in < bar_w);

    // note square
    assign px = `COORD_W'(x_in);
    assign py = `COORD_W'(y_in);
    assign dx = (px >= note.note_x) ? px - note.note_x : note.note_x - px;
    assign dy = (py >= note.note_y) ? py - note.note_y : note.note_y - py;
    assign in_note = note.note_visible && (dx <= `COORD_W'(`NOTE_HALF))
                                       && (dy <= `COORD_W'(`NOTE_HALF));

    //////////////////////////////////////////////////////////////////////
    // colour select, one cycle latency
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            {r_out, g_out, b_out} <= 12'h000;
        end else if (on_bar) begin
            {r_out, g_out, b_out} <= 12'h0F0;
        end else if (in_note) begin
            {r_out, g_out, b_out} <= note.note_color ? 12'h00F : 12'hF00;
        end else if (state == DONE) begin
            {r_out, g_out, b_out} <= 12'h800;
        end else begin
            {r_out, g_out, b_out} <= 12'h000;
        end
    end

endmodule

`default_nettype wire

//--- rhythm_game_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "game_defines.svh"

module rhythm_game_top (
    input wire                    clk_in,
    input wire                    rst_in,
    input wire [`PIX_X_W-1:0]     x_in,
    input wire [`PIX_Y_W-1:0]     y_in,
    input wire [`COORD_W-1:0]     left_x,
    input wire [`COORD_W-1:0]     left_y,
    input wire [`COORD_W-1:0]     right_x,
    input wire [`COORD_W-1:0]     right_y,
    output logic [3:0]            r_out,
    output logic [3:0]            g_out,
    output logic [3:0]            b_out,
    output logic [`SCORE_W-1:0]   score_out,
    output logic [`HEALTH_W-1:0]  health_out,
    output logic [`COMBO_W-1:0]   combo_out,
    output game_pkg::play_state_e state_out
);
    logic [`TIME_W-1:0] curr_time;
    logic               slice;
    logic               miss;

    note_if note ();
    hand_if hands ();

    // hands come straight from the tracker ports
    assign hands.left_x  = left_x;
    assign hands.left_y  = left_y;
    assign hands.right_x = right_x;
    assign hands.right_y = right_y;

    //////////////////////////////////////////////////////////////////////
    // game core
    //////////////////////////////////////////////////////////////////////
    note_track u_track (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .curr_time (curr_time),
        .note      (note)
    );

    slice_judge u_judge (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .note   (note),
        .hands  (hands),
        .slice  (slice),
        .miss   (miss)
    );

    game_state u_state (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .slice     (slice),
        .miss      (miss),
        .all_done  (note.all_done),
        .curr_time (curr_time),
        .score     (score_out),
        .combo     (combo_out),
        .health    (health_out),
        .state     (state_out)
    );

    pixel_renderer u_render (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .x_in   (x_in),
        .y_in   (y_in),
        .health (health_out),
        .state  (state_out),
        .note   (note),
        .r_out  (r_out),
        .g_out  (g_out),
        .b_out  (b_out)
    );

endmodule

`default_nettype wire

//--- rhythm_game_asserts.sv
`timescale 1ns/1ps
`default_nettype none
`include "game_defines.svh"

module rhythm_game_asserts (
    input wire                    clk_in,
    input wire                    rst_in,
    input wire                    slice,
    input wire                    miss,
    input wire [`HEALTH_W-1:0]    health,
    input wire game_pkg::play_state_e state
);
    import game_pkg::*;

    // one pulse per note
    a_one_pulse: assert property (@(posedge clk_in) disable iff (rst_in) !(slice && miss))
        else $error("slice and miss high in the same cycle");

    a_health_down: assert property (@(posedge clk_in) disable iff (rst_in)
        health <= $past(health))
        else $error("health went up");

    // DONE is terminal
    a_done_stays: assert property (@(posedge clk_in) disable iff (rst_in)
        ($past(state) == DONE) |-> (state == DONE))
        else $error("state left DONE");

endmodule

bind rhythm_game_top rhythm_game_asserts u_asserts (
    .clk_in (clk_in),
    .rst_in (rst_in),
    .slice  (slice),
    .miss   (miss),
    .health (health_out),
    .state  (state_out)
);

`default_nettype wire

//--- tb_rhythm_game.sv
`timescale 1ns/1ps
`default_nettype none
`include "game_defines.svh"

module tb_rhythm_game;
    import game_pkg::*;

    // last note hit time plus window and slack, in cycles
    localparam int TIMEOUT = (80 + `HIT_WINDOW + 20) * `TICK_CYCLES + 200;

    logic                  clk_in = 1'b0;
    logic                  rst_in;
    logic [`PIX_X_W-1:0]   x_in;
    logic [`PIX_Y_W-1:0]   y_in;
    logic [`COORD_W-1:0]   left_x, left_y, right_x, right_y;
    logic [3:0]            r_out, g_out, b_out;
    logic [`SCORE_W-1:0]   score_out;
    logic [`HEALTH_W-1:0]  health_out;
    logic [`COMBO_W-1:0]   combo_out;
    play_state_e           state_out;
    int                    cycles = 0;
    bit                    run_ok = 1'b0;
    bit                    fail_reported = 1'b0;

    rhythm_game_top u_dut (.*);

    always #2 clk_in = ~clk_in;

    task automatic abort_run(input string why);
        fail_reported = 1'b1;
        $display("Regression failed");
        $fatal(1, why);
    endtask

    task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            abort_run("value mismatch");
        end
    endtask

    task automatic check_game(input int score, input int combo, input int health);
        check_hex("score_out", 32'(score_out), 32'(score));
        check_hex("combo_out", 32'(combo_out), 32'(combo));
        check_hex("health_out", 32'(health_out), 32'(health));
    endtask

    // present one pixel, read it back after the register stage
    task automatic check_pixel(input int x, input int y, input logic [11:0] exp);
        x_in = `PIX_X_W'(x);
        y_in = `PIX_Y_W'(y);
        @(negedge clk_in);
        check_hex("rgb", {20'h0, r_out, g_out, b_out}, {20'h0, exp});
    endtask

    task automatic place_hands(input int lx, input int ly, input int rx, input int ry);
        left_x  = `COORD_W'(lx);
        left_y  = `COORD_W'(ly);
        right_x = `COORD_W'(rx);
        right_y = `COORD_W'(ry);
    endtask

    task automatic wait_tick(input int t);
        while (int'(u_dut.curr_time) < t) @(negedge clk_in);
    endtask

    task automatic wait_score_change();
        logic [`SCORE_W-1:0] old;
        old = score_out;
        while (score_out == old) @(negedge clk_in);
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////
    task automatic test_reset();
        check_game(0, 0, `MAX_HEALTH);
        check_hex("state_out", 32'(state_out), 32'(PLAYING));
        check_pixel(10, 5, 12'h0F0);
    endtask

    task automatic test_slice();
        wait_tick(18);
        place_hands(205, 150, 0, 0);
        wait_score_change();
        check_game(1, 1, `MAX_HEALTH);
        place_hands(0, 0, 0, 0);
    endtask

    task automatic test_wrong_hand();
        // blue note aimed at with the left hand only
        place_hands(400, 150, 0, 0);
        while (health_out == `HEALTH_W'(`MAX_HEALTH)) begin
            check_hex("score_out", 32'(score_out), 32'd1);
            @(negedge clk_in);
        end
        check_game(1, 0, 7);
        place_hands(0, 0, 0, 0);
        check_pixel(7 * `HEALTH_SEG + 5, 5, 12'h000);
    endtask

    task automatic test_note_draw();
        wait_tick(52);
        check_pixel(300, 300, 12'hF00);
        check_pixel(300, 340, 12'h000);
        place_hands(300, 300, 0, 0);
        wait_score_change();
        check_game(2, 1, 7);
        place_hands(0, 0, 0, 0);
    endtask

    task automatic test_combo_end();
        place_hands(0, 0, 500, 310);
        wait_score_change();
        check_game(4, 2, 7);
        place_hands(0, 0, 0, 0);
        while (state_out != DONE) @(negedge clk_in);
        check_pixel(600, 400, 12'h800);
    endtask

    initial begin
        rst_in = 1'b1;
        x_in   = '0;
        y_in   = '0;
        place_hands(0, 0, 0, 0);
        repeat (16) @(negedge clk_in);
        rst_in = 1'b0;
        test_reset();
        test_slice();
        test_wrong_hand();
        test_note_draw();
        test_combo_end();
        run_ok = 1'b1;
        $display("Regression passed");
        $finish;
    end

    always @(posedge clk_in) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            abort_run("timeout, the game did not finish within the cycle limit");
        end
    end

    // run stopped by a failed bound assertion
    final begin
        if (!run_ok && !fail_reported) begin
            $display("Regression failed");
        end
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
game_pkg.sv
game_ifs.sv
note_track.sv
slice_judge.sv
game_state.sv
pixel_renderer.sv
rhythm_game_top.sv
rhythm_game_asserts.sv
tb_rhythm_game.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wall -Wno-fatal
TOP      = tb_rhythm_game
FILELIST = verilog.f

BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
SRCS     = $(filter-out +incdir+%,$(shell cat $(FILELIST))) game_defines.svh
LOG      = sim.log

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
